// File: icache_fetch.f
+incdir+.
icache_pkg.sv
fetch_pkg.sv
bram_block.sv
icache_line_pack.sv
icache_lookup.sv
icache_refill.sv
icache_fetch.sv
icache_fetch_tb.sv

// File: Bender.yml
package:
  name: icache_fetch

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - icache_pkg.sv
      - fetch_pkg.sv
      - bram_block.sv
      - icache_line_pack.sv
      - icache_lookup.sv
      - icache_refill.sv
      - icache_fetch.sv
  - target: test
    include_dirs:
      - .
    files:
      - icache_fetch_tb.sv

// File: icache_fetch_tb.sv
`timescale 1ns/1ps

`include "icache_consts.svh"

module icache_fetch_tb;

	import icache_pkg::*;
	import fetch_pkg::*;

	localparam int RESET_CYCLES  = 10;
	localparam int DIRECTED_REQS = 9;
	localparam int RANDOM_REQS   = 300;
	localparam int CYCLE_LIMIT   = 20 * (DIRECTED_REQS + RANDOM_REQS) + RESET_CYCLES;
	localparam logic [63:0] SEED = 64'd13430;

	logic                clk;
	logic                rst;
	logic                req;
	fetch_req_t          req_addr;
	logic                ready;
	logic                resp_valid;
	logic [`INSTR_W-1:0] resp_data;
	logic                mem_req;
	fetch_req_t          mem_addr;
	logic                mem_rvalid = 1'b0;
	logic [`INSTR_W-1:0] mem_rdata = '0;

	logic        started;
	logic        pred_hit;
	string       test_name;
	int          mismatch_count;
	int          protocol_count;
	int          cycle_count;
	logic [63:0] stim_rng;
	logic [63:0] delay_rng;

	// expected tag store, one entry per line
	logic [`TAG_W-1:0] ref_tag [0:(1 << `BRAM_ADDR_W)-1];
	logic              ref_valid [0:(1 << `BRAM_ADDR_W)-1];

	logic        mem_busy;
	int          mem_wait;
	fetch_req_t  mem_addr_q;
	cache_addr_t pool [0:23];

	icache_fetch i_icache_fetch (
		.clk        (clk),
		.rst        (rst),
		.req        (req),
		.req_addr   (req_addr),
		.ready      (ready),
		.resp_valid (resp_valid),
		.resp_data  (resp_data),
		.mem_req    (mem_req),
		.mem_addr   (mem_addr),
		.mem_rvalid (mem_rvalid),
		.mem_rdata  (mem_rdata)
	);

	function automatic logic [63:0] xorshift64(input logic [63:0] x);
		logic [63:0] y;
		y = x;
		y = y ^ (y << 13);
		y = y ^ (y >> 7);
		y = y ^ (y << 17);
		return y;
	endfunction

	// backing memory contents depend on every address bit
	function automatic logic [`INSTR_W-1:0] mem_word(input logic [`ALIGNED_ADDR_W-1:0] addr);
		return xorshift64({{(64 - `ALIGNED_ADDR_W){1'b0}}, addr});
	endfunction

	// one core fetch, prediction taken from the tag store
	task automatic fetch_word(input string name, input cache_addr_t addr);
		logic hit_p;
		@(negedge clk);
		while (!ready) begin
			@(negedge clk);
		end
		hit_p = ref_valid[addr.index] && (ref_tag[addr.index] == addr.tag);
		if (!hit_p) begin
			ref_valid[addr.index] = 1'b1;
			ref_tag[addr.index]   = addr.tag;
		end
		test_name = name;
		@(posedge clk);
		req      <= 1'b1;
		req_addr <= fetch_req_t'(addr);
		pred_hit <= hit_p;
		started  <= 1'b1;
		@(posedge clk);
		req <= 1'b0;
		@(negedge clk);
		while (!resp_valid) begin
			@(negedge clk);
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// memory answers 1 to 6 cycles after the strobe
	always @(posedge clk) begin : mem_model
		int delay;
		mem_rvalid <= 1'b0;
		if (rst) begin
			mem_busy <= 1'b0;
			mem_wait <= 0;
		end else if (mem_req) begin
			delay_rng = xorshift64(delay_rng);
			delay = int'(delay_rng % 64'd6) + 1;
			mem_addr_q <= mem_addr;
			if (delay == 1) begin
				mem_rvalid <= 1'b1;
				mem_rdata  <= mem_word(mem_addr);
			end else begin
				mem_busy <= 1'b1;
				mem_wait <= delay - 1;
			end
		end else if (mem_busy) begin
			if (mem_wait == 1) begin
				mem_busy   <= 1'b0;
				mem_rvalid <= 1'b1;
				mem_rdata  <= mem_word(mem_addr_q);
			end else begin
				mem_wait <= mem_wait - 1;
			end
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("timeout: no end of test after %0d cycles", CYCLE_LIMIT);
			$display("errors: %0d mismatch, %0d protocol", mismatch_count, protocol_count);
			$display("Simulation failed");
			$finish;
		end
	end

	// quiet outputs until the first request
	idle_after_reset: assert property (@(posedge clk) disable iff (rst)
		!started |-> ready && !resp_valid && !mem_req)
		else begin
			protocol_count++;
			$display("outputs not idle after reset before the first request");
		end

	hit_timing: assert property (@(posedge clk) disable iff (rst)
		req && pred_hit |=> resp_valid && !mem_req)
		else begin
			protocol_count++;
			$display("%s: expected hit got no response one cycle after req", test_name);
		end

	miss_timing: assert property (@(posedge clk) disable iff (rst)
		req && !pred_hit |=> mem_req && !resp_valid)
		else begin
			protocol_count++;
			$display("%s: expected miss got no mem_req one cycle after req", test_name);
		end

	miss_address: assert property (@(posedge clk) disable iff (rst)
		mem_req |-> mem_addr == req_addr)
		else begin
			mismatch_count++;
			$display("MISMATCH %s mem_addr expected %h actual %h", test_name,
				$sampled(req_addr), $sampled(mem_addr));
		end

	resp_value: assert property (@(posedge clk) disable iff (rst)
		resp_valid |-> resp_data == mem_word(req_addr))
		else begin
			mismatch_count++;
			$display("MISMATCH %s resp_data expected %h actual %h", test_name,
				mem_word($sampled(req_addr)), $sampled(resp_data));
		end

	ready_drop: assert property (@(posedge clk) disable iff (rst) req |=> !ready)
		else begin
			protocol_count++;
			$display("%s: ready still high after an accepted request", test_name);
		end

	ready_return: assert property (@(posedge clk) disable iff (rst) resp_valid |=> ready)
		else begin
			protocol_count++;
			$display("%s: ready not back one cycle after the response", test_name);
		end

	refill_response: assert property (@(posedge clk) disable iff (rst)
		mem_rvalid |-> resp_valid)
		else begin
			protocol_count++;
			$display("%s: no response in the memory data cycle", test_name);
		end

	single_mem_req: assert property (@(posedge clk) disable iff (rst) mem_req |=> !mem_req)
		else begin
			protocol_count++;
			$display("%s: mem_req longer than one cycle", test_name);
		end

	// the miss address stays on the requested fetch while memory is busy
	mem_addr_hold: assert property (@(posedge clk) disable iff (rst)
		mem_busy |-> mem_addr == req_addr)
		else begin
			mismatch_count++;
			$display("MISMATCH %s held mem_addr expected %h actual %h", test_name,
				$sampled(req_addr), $sampled(mem_addr));
		end

	initial begin
		rst            = 1'b1;
		req            = 1'b0;
		req_addr       = '0;
		started        = 1'b0;
		pred_hit       = 1'b0;
		mismatch_count = 0;
		protocol_count = 0;
		cycle_count    = 0;
		stim_rng       = SEED;
		delay_rng      = SEED;
		test_name      = "reset";
		for (int i = 0; i < (1 << `BRAM_ADDR_W); i++) begin
			ref_valid[i] = 1'b0;
			ref_tag[i]   = '0;
		end

		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
		repeat (3) @(posedge clk);

		fetch_word("cold_miss", '{tag: 15'h0123, index: 8'h05});
		fetch_word("repeat_hit", '{tag: 15'h0123, index: 8'h05});
		fetch_word("repeat_hit", '{tag: 15'h0123, index: 8'h05});

		// same index, two tags, index 9 stays put
		fetch_word("evict", '{tag: 15'h0123, index: 8'h09});
		for (int n = 0; n < 2; n++) begin
			fetch_word("evict", '{tag: 15'h02a7, index: 8'h05});
			fetch_word("evict", '{tag: 15'h0123, index: 8'h05});
		end
		fetch_word("evict", '{tag: 15'h0123, index: 8'h09});

		// 4 tags on each of 6 lines
		for (int i = 0; i < 6; i++) begin
			for (int t = 0; t < 4; t++) begin
				stim_rng = xorshift64(stim_rng);
				pool[i * 4 + t].index = 8'(i * 41 + 3);
				pool[i * 4 + t].tag   = {stim_rng[14:2], 2'(t)};
			end
		end
		for (int n = 0; n < RANDOM_REQS; n++) begin
			stim_rng = xorshift64(stim_rng);
			fetch_word("random", pool[int'(stim_rng % 64'd24)]);
		end

		repeat (4) @(posedge clk);
		$display("errors: %0d mismatch, %0d protocol", mismatch_count, protocol_count);
		if (mismatch_count == 0 && protocol_count == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: icache_fetch.sv
`timescale 1ns/1ps

`include "icache_consts.svh"

module icache_fetch (
	input  logic                  clk,
	input  logic                  rst,

	// core side
	input  logic                  req,
	input  fetch_pkg::fetch_req_t req_addr,
	output logic                  ready,
	output logic                  resp_valid,
	output logic [`INSTR_W-1:0]   resp_data,

	// memory side
	output logic                  mem_req,
	output fetch_pkg::fetch_req_t mem_addr,
	input  logic                  mem_rvalid,
	input  logic [`INSTR_W-1:0]   mem_rdata
);

	import icache_pkg::*;

	logic                    wr_en;
	cache_addr_t             wr_addr;
	logic [`INSTR_W-1:0]     wr_data;
	cache_addr_t             rd_addr;
	logic                    hit;
	logic [`INSTR_W-1:0]     line_rdata;

	logic [`BRAM_BLOCKS-1:0] block_we;
	block_words_t            block_wdata;
	block_words_t            block_rdata;
	logic [`BRAM_ADDR_W-1:0] line_waddr;
	logic [`BRAM_ADDR_W-1:0] line_raddr;

	icache_refill i_refill (
		.clk        (clk),
		.rst        (rst),
		.req        (req),
		.req_addr   (req_addr),
		.ready      (ready),
		.resp_valid (resp_valid),
		.resp_data  (resp_data),
		.mem_req    (mem_req),
		.mem_addr   (mem_addr),
		.mem_rvalid (mem_rvalid),
		.mem_rdata  (mem_rdata),
		.hit        (hit),
		.line_rdata (line_rdata),
		.wr_en      (wr_en),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data),
		.rd_addr    (rd_addr)
	);

	icache_line_pack i_line_pack (
		.write_enable (wr_en),
		.waddr        (wr_addr),
		.wdata        (wr_data),
		.raddr        (rd_addr),
		.block_we     (block_we),
		.block_wdata  (block_wdata),
		.line_waddr   (line_waddr),
		.line_raddr   (line_raddr)
	);

	// one block per 16-bit slice of the line
	for (genvar i = 0; i < `BRAM_BLOCKS; i++) begin : g_block
		bram_block i_bram_block (
			.clk   (clk),
			.we    (block_we[i]),
			.waddr (line_waddr),
			.wdata (block_wdata[i]),
			.raddr (line_raddr),
			.rdata (block_rdata[i])
		);
	end

	icache_lookup i_lookup (
		.clk         (clk),
		.rst         (rst),
		.rd_tag      (rd_addr.tag),
		.block_rdata (block_rdata),
		.rdata       (line_rdata),
		.hit         (hit)
	);

endmodule

// File: icache_refill.sv
`timescale 1ns/1ps

`include "icache_consts.svh"

module icache_refill (
	input  logic                    clk,
	input  logic                    rst,

	// core side
	input  logic                    req,
	input  fetch_pkg::fetch_req_t   req_addr,
	output logic                    ready,
	output logic                    resp_valid,
	output logic [`INSTR_W-1:0]     resp_data,

	// memory side
	output logic                    mem_req,
	output fetch_pkg::fetch_req_t   mem_addr,
	input  logic                    mem_rvalid,
	input  logic [`INSTR_W-1:0]     mem_rdata,

	// cache array
	input  logic                    hit,
	input  logic [`INSTR_W-1:0]     line_rdata,
	output logic                    wr_en,
	output icache_pkg::cache_addr_t wr_addr,
	output logic [`INSTR_W-1:0]     wr_data,
	output icache_pkg::cache_addr_t rd_addr
);

	import fetch_pkg::*;
	import icache_pkg::*;

	fetch_state_e state;
	fetch_state_e state_next;

	// address of the request in flight
	fetch_req_t req_q;

	logic accept;
	logic lookup_hit;
	logic refill_done;

	assign accept      = (state == IDLE) && req;
	assign lookup_hit  = (state == LOOKUP) && hit;
	assign refill_done = (state == MISS_WAIT) && mem_rvalid;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
		end else begin
			state <= state_next;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			req_q <= req_addr;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			IDLE: begin
				if (req) begin
					state_next = LOOKUP;
				end
			end
			LOOKUP: begin
				// a miss goes to memory, a hit is done
				if (hit) begin
					state_next = IDLE;
				end else begin
					state_next = MISS_WAIT;
				end
			end
			MISS_WAIT: begin
				if (mem_rvalid) begin
					state_next = IDLE;
				end
			end
			default: begin
				state_next = IDLE;
			end
		endcase
	end

	// core accepts requests only in IDLE
	assign ready = (state == IDLE);

	// the read starts in the request cycle straight from the core address
	assign rd_addr = cache_addr_t'(req_addr.addr);

	// memory read strobe for one cycle, address held until data returns
	assign mem_req  = (state == LOOKUP) && !hit;
	assign mem_addr = req_q;

	// refill write lands in the same cycle as the memory data
	assign wr_en   = refill_done;
	assign wr_addr = cache_addr_t'(req_q.addr);
	assign wr_data = mem_rdata;

	// answer from the cache on a hit, from memory on a refill
	assign resp_valid = lookup_hit || refill_done;
	assign resp_data  = (state == MISS_WAIT) ? mem_rdata : line_rdata;

endmodule

// File: icache_lookup.sv
`timescale 1ns/1ps

`include "icache_consts.svh"

module icache_lookup (
	input  logic                     clk,
	input  logic                     rst,
	input  logic [`TAG_W-1:0]        rd_tag,
	input  icache_pkg::block_words_t block_rdata,
	output logic [`INSTR_W-1:0]      rdata,
	output logic                     hit
);

	import icache_pkg::*;

	logic [`TAG_W-1:0] tag_q;
	cache_line_t       rline;

	// delay the tag by one cycle
	// block outputs appear one cycle after the read address
	always_ff @(posedge clk) begin
		if (rst) begin
			tag_q <= '0;
		end else begin
			tag_q <= rd_tag;
		end
	end

	// put the line back together from the block words
	assign rline = cache_line_t'(block_rdata);

	assign rdata = rline.data;

	// hit needs a valid line with a matching tag
	assign hit = rline.valid && (rline.tag == tag_q);

endmodule

// File: icache_line_pack.sv
`timescale 1ns/1ps

`include "icache_consts.svh"

module icache_line_pack (
	input  logic                       write_enable,
	input  icache_pkg::cache_addr_t    waddr,
	input  logic [`INSTR_W-1:0]        wdata,
	input  icache_pkg::cache_addr_t    raddr,
	output logic [`BRAM_BLOCKS-1:0]    block_we,
	output icache_pkg::block_words_t   block_wdata,
	output logic [`BRAM_ADDR_W-1:0]    line_waddr,
	output logic [`BRAM_ADDR_W-1:0]    line_raddr
);

	import icache_pkg::*;

	cache_line_t wline;

	// a refilled line is always valid
	always_comb begin
		wline.tag   = waddr.tag;
		wline.valid = 1'b1;
		wline.data  = wdata;
	end

	// slice the line into one 16-bit word per block
	assign block_wdata = block_words_t'(wline);

	// all blocks of a line are written together
	assign block_we = {`BRAM_BLOCKS{write_enable}};

	// only the index reaches the blocks
	// the read tag is compared later in the lookup
	assign line_waddr = waddr.index;
	assign line_raddr = raddr.index;

endmodule

// File: bram_block.sv
`timescale 1ns/1ps

`include "icache_consts.svh"

module bram_block (
	input  logic                    clk,
	input  logic                    we,
	input  logic [`BRAM_ADDR_W-1:0] waddr,
	input  logic [`BRAM_DATA_W-1:0] wdata,
	input  logic [`BRAM_ADDR_W-1:0] raddr,
	output logic [`BRAM_DATA_W-1:0] rdata
);

	logic [`BRAM_DATA_W-1:0] mem [0:(1 << `BRAM_ADDR_W)-1];

	// the FPGA loads block RAM with zeros at configuration
	initial begin
		for (int i = 0; i < (1 << `BRAM_ADDR_W); i++) begin
			mem[i] = '0;
		end
	end

	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// registered read
	// a write to the same word in this cycle is forwarded
	always_ff @(posedge clk) begin
		if (we && waddr == raddr) begin
			rdata <= wdata;
		end else begin
			rdata <= mem[raddr];
		end
	end

endmodule

// File: fetch_pkg.sv
`include "icache_consts.svh"

package fetch_pkg;

	// 64-bit aligned fetch address
	// same shape on the core side and on the memory side
	typedef struct packed {
		logic [`ALIGNED_ADDR_W-1:0] addr;
	} fetch_req_t;

	// refill controller states
	// IDLE       ready for a core request
	// LOOKUP     block output and tag compare are valid
	// MISS_WAIT  memory read outstanding
	typedef enum logic [1:0] {
		IDLE,
		LOOKUP,
		MISS_WAIT
	} fetch_state_e;

endpackage

// File: icache_pkg.sv
`include "icache_consts.svh"

package icache_pkg;

	// aligned fetch address as the cache splits it
	// upper bits are the tag, lower bits select the line
	typedef struct packed {
		logic [`TAG_W-1:0]       tag;
		logic [`BRAM_ADDR_W-1:0] index;
	} cache_addr_t;

	// stored line layout, MSB first
	// | tag | valid | data |
	typedef struct packed {
		logic [`TAG_W-1:0]   tag;
		logic                valid;
		logic [`INSTR_W-1:0] data;
	} cache_line_t;

	// one line laid across the blocks
	// word 0 holds the lowest 16 data bits, word 4 the tag and valid
	typedef logic [`BRAM_BLOCKS-1:0][`BRAM_DATA_W-1:0] block_words_t;

endpackage

// File: icache_consts.svh
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// fetch address width of the core
`define ALEN 26

// one fetch word is 64 bits, so the low 3 address bits are dropped
`define ALIGN_BITS 3
`define ALIGNED_ADDR_W (`ALEN - `ALIGN_BITS)

// two uncompressed or four compressed instructions
`define INSTR_W 64

// iCE40 block RAM geometry, 256 x 16 per block
`define BRAM_BLOCKS 5
`define BRAM_ADDR_W 8
`define BRAM_DATA_W 16

// one cache line spread over all blocks
`define LINE_W (`BRAM_BLOCKS * `BRAM_DATA_W)

// what remains of the line after data and the valid flag
`define TAG_W (`LINE_W - `INSTR_W - 1)

// these only line up for ALEN = 26:
// 23 aligned bits = 15 tag + 8 index
// 80 line bits = 15 tag + 1 valid + 64 data

`endif
